/* design/mem_stage_pkg.sv */
//======================================================================
// Memory stage package
// Widths, funct3 size and load codes, the load word view and the
// data memory handshake states shared by the MEM stage blocks
//======================================================================

`default_nettype none

package mem_stage_pkg;

    //==================================================================
    // Widths
    //==================================================================
    localparam int XLEN       = 32;           // Data and address width
    localparam int REG_ADDR_W = 5;            // Register number
    localparam int MASK_W     = XLEN / 8;     // One enable per byte lane
    localparam int FUNCT3_W   = 3;

    //==================================================================
    // funct3 codes
    //==================================================================
    localparam logic [1:0] SIZE_BYTE = 2'b00; // funct3[1:0] access size
    localparam logic [1:0] SIZE_HALF = 2'b01;
    localparam logic [1:0] SIZE_WORD = 2'b10;

    localparam logic [FUNCT3_W-1:0] F3_LB  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_LH  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_LW  = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_LBU = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_LHU = 3'b101;

    // One read word, seen as byte lanes or as halfword lanes
    typedef union packed {
        logic [MASK_W-1:0][7:0]  bytes;     // Lane n = bits 8n+7:8n
        logic [1:0][XLEN/2-1:0]  halves;    // Lane 1 = upper halfword
    } load_word_u;

    // Four-phase req/ack master states
    typedef enum logic [1:0] {
        IDLE    = 2'd0,   // No access pending
        REQ     = 2'd1,   // req high, waiting for ack
        RELEASE = 2'd2,   // req dropped, waiting for ack low
        DONE    = 2'd3    // One cycle, result valid
    } port_state_e;

endpackage

`default_nettype wire

/* design/ex_mem_if.sv */
//======================================================================
// EX/MEM bus
// Registered instruction fields from the pipeline register to the
// decode, memory port and load blocks
//======================================================================

`timescale 1ns/10ps
`default_nettype none

interface ex_mem_if;
    import mem_stage_pkg::*;

    logic                  valid;       // Entry holds an instruction
    logic [XLEN-1:0]       alu_result;  // Address for loads and stores
    logic [XLEN-1:0]       store_data;  // rs2 value, unshifted
    logic [REG_ADDR_W-1:0] rd;
    logic [FUNCT3_W-1:0]   funct3;      // Size and sign of access
    logic                  mem_read;
    logic                  mem_write;
    logic                  mem_to_reg;  // Writeback from load data
    logic                  reg_write;

    modport producer (output valid, alu_result, store_data, rd, funct3,
                      mem_read, mem_write, mem_to_reg, reg_write);
    modport consumer (input  valid, alu_result, store_data, rd, funct3,
                      mem_read, mem_write, mem_to_reg, reg_write);

endinterface

`default_nettype wire

/* design/ex_mem_reg.sv */
//======================================================================
// EX/MEM pipeline register
// Captures the execute stage result, holds it while a data access
// stalls the stage
//======================================================================

`timescale 1ns/10ps
`default_nettype none

module ex_mem_reg (
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  logic                               i_stall,      // Hold current entry
    input  logic                               i_valid,
    input  logic [mem_stage_pkg::XLEN-1:0]     i_alu_result,
    input  logic [mem_stage_pkg::XLEN-1:0]     i_store_data,
    input  logic [mem_stage_pkg::REG_ADDR_W-1:0] i_rd,
    input  logic [mem_stage_pkg::FUNCT3_W-1:0] i_funct3,
    input  logic                               i_mem_read,
    input  logic                               i_mem_write,
    input  logic                               i_mem_to_reg,
    input  logic                               i_reg_write,
    ex_mem_if.producer                         o_ex
);

    //==================================================================
    // Control fields
    //==================================================================
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ex.valid      <= 1'b0;
            o_ex.mem_read   <= 1'b0;
            o_ex.mem_write  <= 1'b0;
            o_ex.mem_to_reg <= 1'b0;
            o_ex.reg_write  <= 1'b0;
        end else if (!i_stall) begin
            o_ex.valid      <= i_valid;        // Bubble when EX has nothing
            o_ex.mem_read   <= i_mem_read;
            o_ex.mem_write  <= i_mem_write;
            o_ex.mem_to_reg <= i_mem_to_reg;
            o_ex.reg_write  <= i_reg_write;
        end
    end

    //==================================================================
    // Payload fields
    //==================================================================
    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            o_ex.alu_result <= i_alu_result;
            o_ex.store_data <= i_store_data;
            o_ex.rd         <= i_rd;
            o_ex.funct3     <= i_funct3;
        end
    end

    // EX never issues a load and a store in one instruction
    a_one_access: assert property (@(posedge i_clk) disable iff (i_rst)
        o_ex.valid |-> !(o_ex.mem_read && o_ex.mem_write));

endmodule

`default_nettype wire

/* design/access_decode.sv */
//======================================================================
// Access decode
// Word address, byte enables, store lane shift and misalignment
// check for the held load or store
//======================================================================

`timescale 1ns/10ps
`default_nettype none

module access_decode (
    ex_mem_if.consumer                        i_ex,
    output logic [mem_stage_pkg::XLEN-1:0]    o_addr,       // Word aligned
    output logic [mem_stage_pkg::MASK_W-1:0]  o_mask,       // Byte enables
    output logic [mem_stage_pkg::XLEN-1:0]    o_wdata,      // Store data on its lanes
    output logic                              o_misaligned
);
    import mem_stage_pkg::*;

    logic [1:0]        offset;      // Byte within word
    logic [1:0]        size;
    logic [MASK_W-1:0] base_mask;   // Enables at offset zero

    assign offset = i_ex.alu_result[1:0];
    assign size   = i_ex.funct3[1:0];

    assign o_addr = {i_ex.alu_result[XLEN-1:2], 2'b00};

    always_comb begin
        case (size)
            SIZE_BYTE: base_mask = 4'b0001;
            SIZE_HALF: base_mask = 4'b0011;
            default:   base_mask = 4'b1111;   // SW
        endcase
    end

    assign o_mask  = base_mask << offset;
    assign o_wdata = i_ex.store_data << {offset, 3'b000};  // 8 bits per byte

    // Halfword at odd offset or word off a word boundary
    assign o_misaligned = (i_ex.mem_read || i_ex.mem_write) &&
                          (((size == SIZE_HALF) && offset[0]) ||
                           ((size == SIZE_WORD) && (offset != 2'b00)));

endmodule

`default_nettype wire

/* design/dmem_port.sv */
//======================================================================
// Data memory port
// Four-phase req/ack master: runs one access per held load or store,
// latches read data and stalls the stage until the access is done
//======================================================================

`timescale 1ns/10ps
`default_nettype none

module dmem_port (
    input  logic                              i_clk,
    input  logic                              i_rst,
    ex_mem_if.consumer                        i_ex,
    input  logic [mem_stage_pkg::XLEN-1:0]    i_addr,
    input  logic [mem_stage_pkg::MASK_W-1:0]  i_mask,
    input  logic [mem_stage_pkg::XLEN-1:0]    i_wdata,
    input  logic                              i_misaligned,
    output logic                              o_dmem_req,
    output logic                              o_dmem_we,
    output logic [mem_stage_pkg::XLEN-1:0]    o_dmem_addr,
    output logic [mem_stage_pkg::MASK_W-1:0]  o_dmem_mask,
    output logic [mem_stage_pkg::XLEN-1:0]    o_dmem_wdata,
    input  logic                              i_dmem_ack,
    input  logic [mem_stage_pkg::XLEN-1:0]    i_dmem_rdata,
    output logic [mem_stage_pkg::XLEN-1:0]    o_rdata,      // Latched load word
    output logic                              o_stall
);
    import mem_stage_pkg::*;

    port_state_e state;
    port_state_e state_nxt;
    logic        access;    // Held entry needs memory

    assign access = i_ex.valid && (i_ex.mem_read || i_ex.mem_write) && !i_misaligned;

    //==================================================================
    // Handshake FSM
    //==================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (access)      state_nxt = REQ;
            REQ:     if (i_dmem_ack)  state_nxt = RELEASE;
            RELEASE: if (!i_dmem_ack) state_nxt = DONE;
            default:                  state_nxt = IDLE;   // DONE lasts one cycle
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // First ack-high cycle only
    always_ff @(posedge i_clk) begin
        if ((state == REQ) && i_dmem_ack) begin
            o_rdata <= i_dmem_rdata;
        end
    end

    // req rises straight out of IDLE, no cycle lost
    assign o_dmem_req   = ((state == IDLE) && access) || (state == REQ);
    assign o_dmem_we    = o_dmem_req && i_ex.mem_write;
    assign o_dmem_addr  = i_addr;
    assign o_dmem_mask  = o_dmem_we ? i_mask : '0;           // Zero on reads
    assign o_dmem_wdata = i_wdata;
    assign o_stall      = access && (state != DONE);

    // Request and its payload held until memory answers
    a_req_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_dmem_req && !i_dmem_ack) |=> o_dmem_req && $stable(o_dmem_we) &&
            $stable(o_dmem_addr) && $stable(o_dmem_mask) && $stable(o_dmem_wdata));

    a_req_after_ack_low: assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(o_dmem_req) |-> !i_dmem_ack);

endmodule

`default_nettype wire

/* design/load_unit.sv */
//======================================================================
// Load unit
// Byte or halfword lane select, sign or zero extension and the
// writeback value choice between load data and ALU result
//======================================================================

`timescale 1ns/10ps
`default_nettype none

module load_unit (
    ex_mem_if.consumer                     i_ex,
    input  logic [mem_stage_pkg::XLEN-1:0] i_rdata,
    output logic [mem_stage_pkg::XLEN-1:0] o_wb_data
);
    import mem_stage_pkg::*;

    load_word_u        word;
    logic [1:0]        offset;
    logic [7:0]        byte_lane;
    logic [XLEN/2-1:0] half_lane;
    logic [XLEN-1:0]   load_val;    // Extended load result

    assign word   = i_rdata;
    assign offset = i_ex.alu_result[1:0];

    assign byte_lane = word.bytes[offset];
    assign half_lane = word.halves[offset[1]];   // offset[0] is zero, else misaligned

    //==================================================================
    // Extension by funct3
    //==================================================================
    always_comb begin
        case (i_ex.funct3)
            F3_LB:   load_val = {{(XLEN-8){byte_lane[7]}}, byte_lane};
            F3_LH:   load_val = {{(XLEN/2){half_lane[XLEN/2-1]}}, half_lane};
            F3_LW:   load_val = word;
            F3_LBU:  load_val = {{(XLEN-8){1'b0}}, byte_lane};
            F3_LHU:  load_val = {{(XLEN/2){1'b0}}, half_lane};
            default: load_val = word;            // Reserved codes read whole word
        endcase
    end

    assign o_wb_data = (i_ex.mem_read && i_ex.mem_to_reg) ? load_val : i_ex.alu_result;

endmodule

`default_nettype wire

/* design/mem_stage_top.sv */
//======================================================================
// RV32I memory access stage
// EX/MEM register, access decode, four-phase data memory port and
// load extension with writeback select
//======================================================================

`timescale 1ns/10ps
`default_nettype none

module mem_stage_top (
    input  logic                                 i_clk,
    input  logic                                 i_rst,
    // From execute
    input  logic                                 i_valid,
    input  logic [mem_stage_pkg::XLEN-1:0]       i_alu_result,
    input  logic [mem_stage_pkg::XLEN-1:0]       i_store_data,
    input  logic [mem_stage_pkg::REG_ADDR_W-1:0] i_rd,
    input  logic [mem_stage_pkg::FUNCT3_W-1:0]   i_funct3,
    input  logic                                 i_mem_read,
    input  logic                                 i_mem_write,
    input  logic                                 i_mem_to_reg,
    input  logic                                 i_reg_write,
    output logic                                 o_stall,      // Back-pressure to EX
    // Data memory
    output logic                                 o_dmem_req,
    output logic                                 o_dmem_we,
    output logic [mem_stage_pkg::XLEN-1:0]       o_dmem_addr,
    output logic [mem_stage_pkg::MASK_W-1:0]     o_dmem_mask,
    output logic [mem_stage_pkg::XLEN-1:0]       o_dmem_wdata,
    input  logic                                 i_dmem_ack,
    input  logic [mem_stage_pkg::XLEN-1:0]       i_dmem_rdata,
    // To writeback
    output logic                                 o_valid,
    output logic [mem_stage_pkg::XLEN-1:0]       o_wb_data,
    output logic [mem_stage_pkg::REG_ADDR_W-1:0] o_rd,
    output logic                                 o_reg_write,
    output logic                                 o_misaligned
);
    import mem_stage_pkg::*;

    ex_mem_if ex_bus ();

    logic [XLEN-1:0]   acc_addr;
    logic [MASK_W-1:0] acc_mask;
    logic [XLEN-1:0]   acc_wdata;
    logic              acc_misaligned;
    logic [XLEN-1:0]   load_rdata;      // Word latched by the port

    ex_mem_reg u_ex_mem_reg (
        .i_clk(i_clk), .i_rst(i_rst), .i_stall(o_stall),
        .i_valid(i_valid), .i_alu_result(i_alu_result), .i_store_data(i_store_data),
        .i_rd(i_rd), .i_funct3(i_funct3), .i_mem_read(i_mem_read),
        .i_mem_write(i_mem_write), .i_mem_to_reg(i_mem_to_reg),
        .i_reg_write(i_reg_write), .o_ex(ex_bus.producer)
    );

    access_decode u_access_decode (
        .i_ex(ex_bus.consumer), .o_addr(acc_addr), .o_mask(acc_mask),
        .o_wdata(acc_wdata), .o_misaligned(acc_misaligned)
    );

    dmem_port u_dmem_port (
        .i_clk(i_clk), .i_rst(i_rst), .i_ex(ex_bus.consumer),
        .i_addr(acc_addr), .i_mask(acc_mask), .i_wdata(acc_wdata),
        .i_misaligned(acc_misaligned),
        .o_dmem_req(o_dmem_req), .o_dmem_we(o_dmem_we), .o_dmem_addr(o_dmem_addr),
        .o_dmem_mask(o_dmem_mask), .o_dmem_wdata(o_dmem_wdata),
        .i_dmem_ack(i_dmem_ack), .i_dmem_rdata(i_dmem_rdata),
        .o_rdata(load_rdata), .o_stall(o_stall)
    );

    load_unit u_load_unit (
        .i_ex(ex_bus.consumer), .i_rdata(load_rdata), .o_wb_data(o_wb_data)
    );

    // One pulse per instruction, held back while memory is busy
    assign o_valid      = ex_bus.valid && !o_stall;
    assign o_rd         = ex_bus.rd;
    assign o_reg_write  = ex_bus.valid && ex_bus.reg_write;
    assign o_misaligned = ex_bus.valid && acc_misaligned;  // Access trap, no req issued

endmodule

`default_nettype wire

/* tb/tb_dmem_model.sv */
//======================================================================
// Data memory model
// 256-word memory behind a four-phase req/ack slave with random ack
// delays, byte-masked writes
//======================================================================

`timescale 1ns/10ps
`default_nettype none

module tb_dmem_model #(
    parameter int SEED = 1
) (
    input  logic                                i_clk,
    input  logic                                i_rst,
    input  logic                                i_req,
    input  logic                                i_we,
    input  logic [mem_stage_pkg::XLEN-1:0]      i_addr,
    input  logic [mem_stage_pkg::MASK_W-1:0]    i_mask,
    input  logic [mem_stage_pkg::XLEN-1:0]      i_wdata,
    output logic                                o_ack,
    output logic [mem_stage_pkg::XLEN-1:0]      o_rdata
);

    logic [31:0] mem [0:255];
    integer      seed = SEED;
    int          delay;
    int          idx;
    int          b;

    initial begin
        o_ack   = 1'b0;
        o_rdata = '0;
        for (idx = 0; idx < 256; idx++) mem[idx] = 32'h9e3779b9 * (idx + 1);
    end

    always begin
        @(posedge i_clk);
        if (!i_rst && i_req && !o_ack) begin
            delay = $random(seed) & 3;            // 0 to 3 cycles to ack
            repeat (delay) @(posedge i_clk);
            idx = i_addr[9:2];
            if (i_we) begin
                for (b = 0; b < 4; b++) begin
                    if (i_mask[b]) mem[idx][8*b +: 8] = i_wdata[8*b +: 8];
                end
            end
            o_rdata <= mem[idx];
            o_ack   <= 1'b1;
            do begin
                @(posedge i_clk);
            end while (i_req);                    // Wait for req low
            delay = $random(seed) & 3;
            repeat (delay) @(posedge i_clk);
            o_ack <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* tb/tb_mem_stage.sv */
//======================================================================
// MEM stage testbench
// Issues ALU results, loads and stores to the stage, checks the data
// memory handshake, byte enables and writeback values against a
// byte-addressed reference memory
//======================================================================

`timescale 1ns/10ps
`default_nettype none

module tb_mem_stage;

    localparam int XLEN       = mem_stage_pkg::XLEN;
    localparam int REG_ADDR_W = mem_stage_pkg::REG_ADDR_W;
    localparam int MASK_W     = mem_stage_pkg::MASK_W;
    localparam int CLK_PERIOD = 20;
    localparam int SEED       = 18209;
    localparam int NUM_TESTS  = 100;           // Upper bound on issued instructions
    localparam int MAX_WAIT   = 40;            // Cycles allowed per instruction

    localparam logic [2:0] F3_BYTE   = 3'b000; // LB, SB
    localparam logic [2:0] F3_HALF   = 3'b001; // LH, SH
    localparam logic [2:0] F3_WORD   = 3'b010; // LW, SW
    localparam logic [2:0] F3_BYTE_U = 3'b100; // LBU
    localparam logic [2:0] F3_HALF_U = 3'b101; // LHU

    logic clk;
    logic rst;
    logic valid, mem_read, mem_write, mem_to_reg, reg_write;
    logic [XLEN-1:0]       alu_result, store_data;
    logic [REG_ADDR_W-1:0] rd;
    logic [2:0]            funct3;
    logic stall, dmem_req, dmem_we, dmem_ack;
    logic [XLEN-1:0]       dmem_addr, dmem_wdata, dmem_rdata;
    logic [MASK_W-1:0]     dmem_mask;
    logic wb_valid, wb_reg_write, misaligned;
    logic [XLEN-1:0]       wb_data;
    logic [REG_ADDR_W-1:0] wb_rd;

    integer                seed = SEED;
    logic [7:0]            ref_mem [0:1023];   // Expected memory bytes
    int                    issued;             // Valid instructions driven
    int                    req_starts;         // Rising edges of req
    int                    valid_pulses;
    logic                  req_q;
    logic [MASK_W-1:0]     seen_mask;          // Last store enables on the bus
    logic [XLEN-1:0]       seen_wdata;
    logic [XLEN-1:0]       seen_addr;          // Last requested address
    logic [REG_ADDR_W-1:0] issued_rd;
    logic [XLEN-1:0]       res_wb;             // Outputs at the o_valid pulse
    logic [REG_ADDR_W-1:0] res_rd;
    logic                  res_rw, res_mis;
    int                    res_reqs;           // Requests made by that instruction

    mem_stage_top i_mem_stage_top (
        .i_clk(clk), .i_rst(rst),
        .i_valid(valid), .i_alu_result(alu_result), .i_store_data(store_data),
        .i_rd(rd), .i_funct3(funct3), .i_mem_read(mem_read), .i_mem_write(mem_write),
        .i_mem_to_reg(mem_to_reg), .i_reg_write(reg_write), .o_stall(stall),
        .o_dmem_req(dmem_req), .o_dmem_we(dmem_we), .o_dmem_addr(dmem_addr),
        .o_dmem_mask(dmem_mask), .o_dmem_wdata(dmem_wdata),
        .i_dmem_ack(dmem_ack), .i_dmem_rdata(dmem_rdata),
        .o_valid(wb_valid), .o_wb_data(wb_data), .o_rd(wb_rd),
        .o_reg_write(wb_reg_write), .o_misaligned(misaligned)
    );

    tb_dmem_model #(.SEED(SEED)) u_dmem (
        .i_clk(clk), .i_rst(rst), .i_req(dmem_req), .i_we(dmem_we),
        .i_addr(dmem_addr), .i_mask(dmem_mask), .i_wdata(dmem_wdata),
        .o_ack(dmem_ack), .o_rdata(dmem_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
        assert (act === exp)
        else report_error($sformatf("CHECK FAILED %s: expected %h, actual %h",
                                    name, exp, act));
    endtask

    //==================================================================
    // Bus monitor and protocol checks
    //==================================================================
    always @(posedge clk) begin
        if (rst) begin
            req_starts   <= 0;
            valid_pulses <= 0;
            req_q        <= 1'b0;
        end else begin
            req_q <= dmem_req;
            if (dmem_req && !req_q) req_starts <= req_starts + 1;
            if (wb_valid) valid_pulses <= valid_pulses + 1;
            if (dmem_req) seen_addr <= dmem_addr;
            if (dmem_req && dmem_we) begin
                seen_mask  <= dmem_mask;
                seen_wdata <= dmem_wdata;
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk)
        $fell(rst) |-> !wb_valid && !stall && !dmem_req && !wb_reg_write)
        else report_error("Outputs were not idle when reset was released");
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        dmem_req && !dmem_ack |=> dmem_req && $stable(dmem_addr) && $stable(dmem_wdata))
        else report_error("Request dropped or changed before ack arrived");
    a_req_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(dmem_req) |-> !dmem_ack)
        else report_error("Request raised while ack was still high");
    a_read_mask: assert property (@(posedge clk) disable iff (rst)
        !dmem_we |-> dmem_mask == '0)
        else report_error("Byte mask not zero on a read or idle bus");
    a_trap_no_req: assert property (@(posedge clk) disable iff (rst)
        misaligned |-> !dmem_req && wb_valid)
        else report_error("Misaligned access reached memory or missed its o_valid");

    //==================================================================
    // Stimulus
    //==================================================================
    // Bubble when idle, random junk while the stage holds its entry
    task automatic drive_filler(input logic noise);
        valid      = noise & 1'($random(seed));
        alu_result = $random(seed);
        store_data = $random(seed);
        rd         = REG_ADDR_W'($random(seed));
        funct3     = 3'($random(seed));
        mem_read   = noise & 1'($random(seed));
        mem_write  = noise & 1'($random(seed));
        mem_to_reg = noise & 1'($random(seed));
        reg_write  = noise & 1'($random(seed));
    endtask

    // One instruction in, wait for its o_valid pulse
    task automatic execute(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data,
                           input logic [2:0] f3, input logic rd_en, input logic wr_en,
                           input logic wr_reg);
        int waited;
        int starts;
        starts     = req_starts;
        issued_rd  = REG_ADDR_W'($random(seed));
        valid      = 1'b1;
        alu_result = addr;
        store_data = data;
        rd         = issued_rd;
        funct3     = f3;
        mem_read   = rd_en;
        mem_write  = wr_en;
        mem_to_reg = rd_en;
        reg_write  = wr_reg;
        issued++;
        waited = 0;
        do begin
            @(posedge clk);
            #2;
            drive_filler(stall);
            waited++;
            if (waited > MAX_WAIT)
                report_error("No o_valid pulse for the issued instruction in time");
        end while (!wb_valid);
        res_wb   = wb_data;
        res_rd   = wb_rd;
        res_rw   = wb_reg_write;
        res_mis  = misaligned;
        res_reqs = req_starts - starts;
    endtask

    // Little-endian gather, sign fill unless funct3[2]
    function automatic logic [XLEN-1:0] expected_load(input logic [XLEN-1:0] addr,
                                                      input logic [2:0] f3);
        logic [XLEN-1:0] val;
        int              n;
        int              b;
        n   = 1 << f3[1:0];
        val = '0;
        for (b = 0; b < n; b++) val[8*b +: 8] = ref_mem[addr[9:0] + b];
        for (b = 8 * n; b < XLEN; b++) val[b] = val[8*n-1] & !f3[2];
        return val;
    endfunction

    task automatic store_check(input string name, input logic [XLEN-1:0] addr,
                               input logic [XLEN-1:0] data, input logic [2:0] f3);
        logic [MASK_W-1:0] exp_mask;
        logic [XLEN-1:0]   lane_bits;   // Enabled lanes only
        logic [XLEN-1:0]   exp_lanes;
        int                b;
        exp_mask  = '0;
        lane_bits = '0;
        exp_lanes = '0;
        for (b = 0; b < (1 << f3[1:0]); b++) begin
            exp_mask[addr[1:0] + b]            = 1'b1;
            lane_bits[8*(addr[1:0] + b) +: 8] = 8'hff;
            exp_lanes[8*(addr[1:0] + b) +: 8] = data[8*b +: 8];
            ref_mem[addr[9:0] + b]             = data[8*b +: 8];
        end
        execute(addr, data, f3, 1'b0, 1'b1, 1'b0);
        check_value($sformatf("%s addr", name), addr & 32'hffff_fffc, seen_addr);
        check_value($sformatf("%s mask", name), exp_mask, seen_mask);
        check_value($sformatf("%s wdata", name), exp_lanes, seen_wdata & lane_bits);
        check_value($sformatf("%s requests", name), 1, res_reqs);
    endtask

    task automatic load_check(input string name, input logic [XLEN-1:0] addr,
                              input logic [2:0] f3);
        execute(addr, $random(seed), f3, 1'b1, 1'b0, 1'b1);
        check_value($sformatf("%s addr", name), addr & 32'hffff_fffc, seen_addr);
        check_value($sformatf("%s data", name), expected_load(addr, f3), res_wb);
        check_value($sformatf("%s requests", name), 1, res_reqs);
    endtask

    task automatic trap_check(input string name, input logic [XLEN-1:0] addr,
                              input logic [2:0] f3, input logic is_store);
        execute(addr, $random(seed), f3, !is_store, is_store, !is_store);
        check_value($sformatf("%s flag", name), 1, res_mis);
        check_value($sformatf("%s requests", name), 0, res_reqs);
    endtask

    initial begin
        logic [XLEN-1:0] base;
        int              w;
        int              off;
        clk    = 1'b0;
        rst    = 1'b1;
        issued = 0;
        drive_filler(1'b0);
        repeat (5) @(posedge clk);
        #2;
        check_value("reset outputs", '0, {wb_valid, stall, dmem_req, wb_reg_write});
        rst = 1'b0;

        repeat (4) begin                           // ALU result straight through
            base = $random(seed);
            execute(base, $random(seed), F3_WORD, 1'b0, 1'b0, 1'b1);
            check_value("alu wb_data", base, res_wb);
            check_value("alu rd", issued_rd, res_rd);
            check_value("alu reg_write", 1, res_rw);
            check_value("alu requests", 0, res_reqs);
        end

        store_check("sw", 32'h40, $random(seed), F3_WORD);
        load_check("lw", 32'h40, F3_WORD);

        for (w = 0; w < 4; w++) begin              // Every lane of random words
            base = $random(seed) & 32'h3fc;
            store_check("sw fill", base, $random(seed), F3_WORD);
            for (off = 0; off < 4; off++) begin
                store_check($sformatf("sb off %0d", off), base + off, $random(seed),
                            F3_BYTE);
                load_check($sformatf("lb off %0d", off), base + off, F3_BYTE);
                load_check($sformatf("lbu off %0d", off), base + off, F3_BYTE_U);
                if (off % 2 == 0) begin
                    store_check($sformatf("sh off %0d", off), base + off, $random(seed),
                                F3_HALF);
                    load_check($sformatf("lh off %0d", off), base + off, F3_HALF);
                    load_check($sformatf("lhu off %0d", off), base + off, F3_HALF_U);
                end
            end
        end

        base = 32'h80;
        store_check("sw before trap", base, $random(seed), F3_WORD);
        for (off = 1; off < 4; off++) begin
            trap_check($sformatf("lw off %0d", off), base + off, F3_WORD, 1'b0);
            trap_check($sformatf("sw off %0d", off), base + off, F3_WORD, 1'b1);
            if (off != 2) begin
                trap_check($sformatf("lh off %0d", off), base + off, F3_HALF, 1'b0);
                trap_check($sformatf("sh off %0d", off), base + off, F3_HALF, 1'b1);
            end
        end
        load_check("lw after trap", base, F3_WORD);   // Word must be untouched

        repeat (2) @(posedge clk);
        #2;
        check_value("o_valid pulses", issued, valid_pulses);
        $display("TEST OK");
        $finish;
    end

    // Watchdog
    initial begin
        #(NUM_TESTS * MAX_WAIT * CLK_PERIOD);
        report_error("Watchdog expired before all tests finished");
    end

endmodule

`default_nettype wire

/* compile.f */
design/mem_stage_pkg.sv
design/ex_mem_if.sv
design/ex_mem_reg.sv
design/access_decode.sv
design/dmem_port.sv
design/load_unit.sv
design/mem_stage_top.sv
tb/tb_dmem_model.sv
tb/tb_mem_stage.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - files:
      - design/mem_stage_pkg.sv
      - design/ex_mem_if.sv
      - design/ex_mem_reg.sv
      - design/access_decode.sv
      - design/dmem_port.sv
      - design/load_unit.sv
      - design/mem_stage_top.sv

  - target: test
    files:
      - tb/tb_dmem_model.sv
      - tb/tb_mem_stage.sv
